/* src/narrator_defines.svh */
`ifndef NARRATOR_DEFINES_SVH
`define NARRATOR_DEFINES_SVH

// ============================================================
// Sample rate divider
// ============================================================
`define NARR_DIV_DEFAULT 16'd3472  // About 14.4 kHz at 50 MHz
`define NARR_DIV_STEP    16'd100
`define NARR_DIV_MIN     16'd200
`define NARR_DIV_MAX     16'd20000

// ============================================================
// Phoneme layout and level meter
// ============================================================
// Four bytes per flash word, so 16 samples per phoneme
`define NARR_PHONEME_WORDS 4

`define NARR_METER_LEN 16  // Power of two
`define NARR_LED_W     8

`endif

/* src/narrator_flash_pkg.sv */
package narrator_flash_pkg;

  // Word address into the phoneme flash
  typedef logic [22:0] flash_addr_t;

  // One read word, four packed samples
  typedef logic [31:0] flash_word_t;

  // Fetch side of the sample reader
  typedef enum logic [1:0]
  {
    RD_IDLE,  // No phoneme playing
    RD_REQ,   // flash_read held until accepted
    RD_WAIT,  // Read accepted, data pending
    RD_EMIT   // No read outstanding
  } rd_state_t;

endpackage

/* src/narrator_audio_pkg.sv */
package narrator_audio_pkg;

  typedef logic [7:0] ascii_t;
  typedef logic signed [7:0] sample_t;  // Two's complement audio
  typedef logic [15:0] div_t;           // Clock cycles per sample

  // Result of character classification
  typedef enum logic [1:0]
  {
    PH_VOICED,
    PH_SILENT,
    PH_INVALID
  } phoneme_kind_t;

  typedef enum logic
  {
    SEQ_IDLE,
    SEQ_PLAY
  } seq_state_t;

endpackage

/* src/sample_rate_gen.sv */
`timescale 1ns/1ns
`include "narrator_defines.svh"

module sample_rate_gen (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic                       speed_up,
  input  logic                       speed_down,
  input  logic                       speed_reset,
  output narrator_audio_pkg::div_t   sample_div,
  output logic                       sample_tick
);

  narrator_audio_pkg::div_t tick_cnt;

  // ============================================================
  // Divider register, clamped to the allowed range
  // ============================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      sample_div <= `NARR_DIV_DEFAULT;
    else if (speed_reset)
      sample_div <= `NARR_DIV_DEFAULT;
    else if (speed_up)  // Faster means fewer cycles
    begin
      if (sample_div < `NARR_DIV_MIN + `NARR_DIV_STEP)
        sample_div <= `NARR_DIV_MIN;
      else
        sample_div <= sample_div - `NARR_DIV_STEP;
    end
    else if (speed_down)
    begin
      if (sample_div > `NARR_DIV_MAX - `NARR_DIV_STEP)
        sample_div <= `NARR_DIV_MAX;
      else
        sample_div <= sample_div + `NARR_DIV_STEP;
    end
  end

  // Tick counter, wraps at sample_div - 1
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= sample_div - 16'd1)  // Also catches a divider that just shrank
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

/* src/phoneme_sequencer.sv */
`timescale 1ns/1ns
`include "narrator_defines.svh"

module phoneme_sequencer (
  input  logic                              CLK_50M,
  input  logic                              rst_n,
  input  logic                              char_valid,
  input  narrator_audio_pkg::ascii_t        char_data,
  output logic                              char_ready,
  output logic                              char_error,
  output logic                              phoneme_done,
  output logic                              play_start,
  output logic                              play_silent,
  output narrator_flash_pkg::flash_addr_t   play_base,
  input  logic                              play_done
);

  narrator_audio_pkg::seq_state_t    state;
  narrator_audio_pkg::phoneme_kind_t char_kind;
  logic [4:0]                        letter_idx;  // 0 to 25
  logic                              accept;

  // ============================================================
  // Character classification
  // ============================================================
  always_comb
  begin
    char_kind  = narrator_audio_pkg::PH_INVALID;
    letter_idx = '0;
    if (char_data >= "a" && char_data <= "z")
    begin
      char_kind  = narrator_audio_pkg::PH_VOICED;
      letter_idx = 5'(char_data - "a");
    end
    else if (char_data >= "A" && char_data <= "Z")  // Same phonemes as lower case
    begin
      char_kind  = narrator_audio_pkg::PH_VOICED;
      letter_idx = 5'(char_data - "A");
    end
    else if (char_data == " ")
      char_kind = narrator_audio_pkg::PH_SILENT;
  end

  assign char_ready = (state == narrator_audio_pkg::SEQ_IDLE);
  assign accept     = char_valid && char_ready;

  // ============================================================
  // Idle / play control
  // ============================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= narrator_audio_pkg::SEQ_IDLE;
      play_start   <= 1'b0;
      char_error   <= 1'b0;
      phoneme_done <= 1'b0;
    end
    else
    begin
      play_start   <= 1'b0;  // Pulses by default
      char_error   <= 1'b0;
      phoneme_done <= 1'b0;
      case (state)
        narrator_audio_pkg::SEQ_IDLE:
          if (accept)
          begin
            if (char_kind == narrator_audio_pkg::PH_INVALID)
              char_error <= 1'b1;  // Rejected, stay ready
            else
            begin
              play_start <= 1'b1;
              state      <= narrator_audio_pkg::SEQ_PLAY;
            end
          end
        narrator_audio_pkg::SEQ_PLAY:
          if (play_done)
          begin
            phoneme_done <= 1'b1;
            state        <= narrator_audio_pkg::SEQ_IDLE;
          end
        default: state <= narrator_audio_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Phoneme base address and kind, held through playback
  always_ff @(posedge CLK_50M)
  begin
    if (accept)
    begin
      play_base   <= narrator_flash_pkg::flash_addr_t'(letter_idx * `NARR_PHONEME_WORDS);
      play_silent <= (char_kind == narrator_audio_pkg::PH_SILENT);
    end
  end

endmodule

/* src/flash_sample_reader.sv */
`timescale 1ns/1ns
`include "narrator_defines.svh"

module flash_sample_reader (
  input  logic                              CLK_50M,
  input  logic                              rst_n,
  input  logic                              play_start,
  input  logic                              play_silent,
  input  narrator_flash_pkg::flash_addr_t   play_base,
  output logic                              play_done,
  input  logic                              sample_tick,
  output logic                              flash_read,
  output narrator_flash_pkg::flash_addr_t   flash_address,
  input  logic                              flash_waitrequest,
  input  logic                              flash_readdatavalid,
  input  narrator_flash_pkg::flash_word_t   flash_readdata,
  output narrator_audio_pkg::sample_t       sample,
  output logic                              sample_valid
);

  narrator_flash_pkg::rd_state_t   rd_state;
  narrator_flash_pkg::flash_word_t cur_word;  // Word being unpacked
  narrator_flash_pkg::flash_word_t nxt_word;  // Prefetched word
  logic       cur_valid;
  logic       nxt_valid;
  logic [1:0] byte_idx;
  logic [2:0] words_req;
  logic [4:0] sample_cnt;
  logic       silent_mode;
  logic       emit;
  logic       shift;
  logic       load;
  logic       all_out;

  assign all_out = (sample_cnt == 5'(`NARR_PHONEME_WORDS * 4));
  // A tick with nothing buffered is skipped
  assign emit  = sample_tick && (rd_state != narrator_flash_pkg::RD_IDLE) && !all_out &&
                 (silent_mode || cur_valid);
  assign shift = emit && !silent_mode && (byte_idx == 2'd3);  // Last byte of cur_word
  assign load  = flash_readdatavalid && (rd_state == narrator_flash_pkg::RD_WAIT);

  // ============================================================
  // Fetch FSM and sample counting
  // ============================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_state     <= narrator_flash_pkg::RD_IDLE;
      flash_read   <= 1'b0;
      play_done    <= 1'b0;
      words_req    <= '0;
      sample_cnt   <= '0;
      silent_mode  <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      play_done    <= 1'b0;
      sample_valid <= emit;
      if (emit)
        sample_cnt <= sample_cnt + 5'd1;
      case (rd_state)
        narrator_flash_pkg::RD_IDLE:
          if (play_start)
          begin
            silent_mode <= play_silent;
            words_req   <= '0;
            sample_cnt  <= '0;
            flash_read  <= !play_silent;  // Silence never touches the flash
            if (play_silent)
              rd_state <= narrator_flash_pkg::RD_EMIT;
            else
              rd_state <= narrator_flash_pkg::RD_REQ;
          end
        narrator_flash_pkg::RD_REQ:
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            words_req  <= words_req + 3'd1;
            rd_state   <= narrator_flash_pkg::RD_WAIT;
          end
        narrator_flash_pkg::RD_WAIT:
          if (flash_readdatavalid)
            rd_state <= narrator_flash_pkg::RD_EMIT;
        narrator_flash_pkg::RD_EMIT:
          if (all_out)
          begin
            play_done <= 1'b1;
            rd_state  <= narrator_flash_pkg::RD_IDLE;
          end
          else if (!silent_mode && words_req != 3'(`NARR_PHONEME_WORDS) &&
                   (!nxt_valid || shift))
          begin
            flash_read <= 1'b1;  // A buffer slot is free
            rd_state   <= narrator_flash_pkg::RD_REQ;
          end
        default: rd_state <= narrator_flash_pkg::RD_IDLE;
      endcase
    end
  end

  // Two word buffer occupancy and byte select
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cur_valid <= 1'b0;
      nxt_valid <= 1'b0;
      byte_idx  <= '0;
    end
    else
    begin
      if (emit && !silent_mode)
        byte_idx <= byte_idx + 2'd1;
      if (shift)
      begin
        cur_valid <= nxt_valid || load;
        nxt_valid <= 1'b0;
      end
      else if (load && cur_valid)
        nxt_valid <= 1'b1;
      else if (load)
        cur_valid <= 1'b1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (shift)
      cur_word <= load ? flash_readdata : nxt_word;
    else if (load && cur_valid)
      nxt_word <= flash_readdata;
    else if (load)
      cur_word <= flash_readdata;

    if (rd_state == narrator_flash_pkg::RD_IDLE && play_start)
      flash_address <= play_base;
    else if (rd_state == narrator_flash_pkg::RD_REQ && !flash_waitrequest)
      flash_address <= flash_address + 23'd1;  // Move on once accepted

    if (emit)  // Lowest byte first
      sample <= silent_mode ? '0 : narrator_audio_pkg::sample_t'(cur_word[8*byte_idx +: 8]);
  end

endmodule

/* src/level_meter.sv */
`timescale 1ns/1ns
`include "narrator_defines.svh"

module level_meter (
  input  logic                          CLK_50M,
  input  logic                          rst_n,
  input  narrator_audio_pkg::sample_t   sample,
  input  logic                          sample_valid,
  output logic [`NARR_LED_W-1:0]        led_level
);

  logic [7:0]                            mag;  // At most 128 for a sample of -128
  logic [$clog2(`NARR_METER_LEN)+7:0]    acc;
  logic [$clog2(`NARR_METER_LEN)+7:0]    total;
  logic [$clog2(`NARR_METER_LEN)-1:0]    cnt;
  logic [3:0]                            level;
  logic [`NARR_LED_W-1:0]                bar;

  assign mag   = sample[7] ? (~sample + 8'd1) : sample;
  assign total = acc + mag;
  // Window average over 16 gives the number of lit LEDs
  assign level = 4'(total >> ($clog2(`NARR_METER_LEN) + 4));

  // Thermometer code
  always_comb
  begin
    for (int i = 0; i < `NARR_LED_W; i++)
      bar[i] = (level > i);
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc       <= '0;
      cnt       <= '0;
      led_level <= '0;
    end
    else if (sample_valid)
    begin
      cnt <= cnt + 1'b1;
      if (cnt == `NARR_METER_LEN - 1)
      begin
        led_level <= bar;
        acc       <= '0;  // Start a new window
      end
      else
        acc <= total;
    end
  end

endmodule

/* src/narrator_top.sv */
`timescale 1ns/1ns
`include "narrator_defines.svh"

module narrator_top (
  input  logic                              CLK_50M,
  input  logic                              rst_n,
  input  logic                              char_valid,
  input  narrator_audio_pkg::ascii_t        char_data,
  output logic                              char_ready,
  output logic                              char_error,
  output logic                              phoneme_done,
  input  logic                              speed_up,
  input  logic                              speed_down,
  input  logic                              speed_reset,
  output narrator_audio_pkg::div_t          sample_div,
  output logic                              flash_read,
  output narrator_flash_pkg::flash_addr_t   flash_address,
  input  logic                              flash_waitrequest,
  input  narrator_flash_pkg::flash_word_t   flash_readdata,
  input  logic                              flash_readdatavalid,
  output narrator_audio_pkg::sample_t       sample,
  output logic                              sample_valid,
  output logic [`NARR_LED_W-1:0]            led_level
);

  // Sequencer to reader
  logic                            play_start;
  logic                            play_silent;
  narrator_flash_pkg::flash_addr_t play_base;
  logic                            play_done;
  logic                            sample_tick;

  sample_rate_gen u_rate (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .speed_up(speed_up), .speed_down(speed_down),
    .speed_reset(speed_reset), .sample_div(sample_div), .sample_tick(sample_tick));

  phoneme_sequencer u_seq (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .char_valid(char_valid), .char_data(char_data),
    .char_ready(char_ready), .char_error(char_error), .phoneme_done(phoneme_done),
    .play_start(play_start), .play_silent(play_silent), .play_base(play_base),
    .play_done(play_done));

  flash_sample_reader u_reader (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .play_start(play_start), .play_silent(play_silent),
    .play_base(play_base), .play_done(play_done), .sample_tick(sample_tick),
    .flash_read(flash_read), .flash_address(flash_address),
    .flash_waitrequest(flash_waitrequest), .flash_readdatavalid(flash_readdatavalid),
    .flash_readdata(flash_readdata), .sample(sample), .sample_valid(sample_valid));

  level_meter u_meter (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .sample(sample), .sample_valid(sample_valid),
    .led_level(led_level));

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic CLK_50M,
  output logic rst_n
);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;  // 20 ns period
  end

  // Reset held over 8 rising edges, released with the stimulus delay
  initial
  begin
    rst_n = 1'b0;
    repeat (8) @(posedge CLK_50M);
    #2 rst_n = 1'b1;
  end

endmodule

/* testbench/flash_model.sv */
`timescale 1ns/1ns

module flash_model (
  input  logic                            CLK_50M,
  input  logic                            rst_n,
  input  logic                            read,
  input  narrator_flash_pkg::flash_addr_t address,
  output logic                            waitrequest,
  output narrator_flash_pkg::flash_word_t readdata,
  output logic                            readdatavalid
);

  logic                            busy;
  logic                            fire;
  int                              lat_left;
  narrator_flash_pkg::flash_word_t word;

  // Byte k of word a holds the low 8 bits of 4a+k
  function automatic narrator_flash_pkg::flash_word_t word_at(
    narrator_flash_pkg::flash_addr_t a);
    logic [7:0] b0;
    b0 = 8'(a * 4);
    return {b0 + 8'd3, b0 + 8'd2, b0 + 8'd1, b0};
  endfunction

  // One process, so the single seed covers every random draw
  initial
  begin
    waitrequest   = 1'b1;
    readdatavalid = 1'b0;
    readdata      = '0;
    busy          = 1'b0;
    lat_left      = 0;
    word          = '0;
    void'($urandom(32'h611f));
    forever
    begin
      @(posedge CLK_50M or negedge rst_n);
      if (!rst_n)
      begin
        busy = 1'b0;
        waitrequest   <= #2 1'b1;
        readdatavalid <= #2 1'b0;
      end
      else
      begin
        fire = busy && (lat_left == 0);
        if (fire)
          busy = 1'b0;
        else if (busy)
          lat_left--;
        readdatavalid <= #2 fire;
        if (fire)
          readdata <= #2 word;
        if (read && !waitrequest)  // Accepted on this edge
        begin
          busy     = 1'b1;
          lat_left = $urandom_range(5, 0);  // 1 to 6 cycles
          word     = word_at(address);
        end
        waitrequest <= #2 ($urandom_range(1, 0) == 1);
      end
    end
  end

endmodule

/* testbench/tb_narrator_top.sv */
`timescale 1ns/1ns

module tb_narrator_top;

  localparam int DIV_DEFAULT = 3472;
  localparam int DIV_STEP    = 100;
  localparam int DIV_MIN     = 200;
  localparam int DIV_MAX     = 20000;
  localparam int WAIT_LIMIT  = 400000;  // Slowest phoneme is 320000 cycles

  localparam logic [1:0] MODE_VOICED  = 2'd0;
  localparam logic [1:0] MODE_SILENT  = 2'd1;
  localparam logic [1:0] MODE_INVALID = 2'd2;
  localparam logic [1:0] MODE_IDLE    = 2'd3;

  logic                            CLK_50M;
  logic                            rst_n;
  logic                            char_valid;
  narrator_audio_pkg::ascii_t      char_data;
  logic                            char_ready;
  logic                            char_error;
  logic                            phoneme_done;
  logic                            speed_up;
  logic                            speed_down;
  logic                            speed_reset;
  narrator_audio_pkg::div_t        sample_div;
  logic                            flash_read;
  narrator_flash_pkg::flash_addr_t flash_address;
  logic                            flash_waitrequest;
  narrator_flash_pkg::flash_word_t flash_readdata;
  logic                            flash_readdatavalid;
  narrator_audio_pkg::sample_t     sample;
  logic                            sample_valid;
  logic [7:0]                      led_level;

  // Expectation for the current character
  logic [1:0]                      exp_mode = MODE_IDLE;
  int                              exp_base = 0;
  int                              exp_div = DIV_DEFAULT;
  logic [7:0]                      exp_sample;
  logic [7:0]                      exp_led;
  int                              exp_reads;

  // Per phoneme tally
  int                              cycle = 0;
  int                              smp_cnt = 0;
  int                              mag_sum = 0;
  int                              last_valid = 0;
  int                              exact_gaps = 0;
  int                              reads_acc = 0;
  narrator_flash_pkg::flash_addr_t hold_addr;

  int                              errors = 0;
  int                              errors_at_start = 0;
  int                              tests = 0;

  function automatic int magnitude(logic [7:0] s);
    return s[7] ? 256 - int'(s) : int'(s);
  endfunction

  // One LED per 16 of average magnitude over 16 samples
  function automatic logic [7:0] thermometer(int sum);
    int lit;
    lit = sum / 256;
    if (lit > 8)
      lit = 8;
    return 8'((9'd1 << lit) - 9'd1);
  endfunction

  assign exp_sample = (exp_mode == MODE_SILENT) ? 8'h00 : 8'(4 * exp_base + smp_cnt);
  assign exp_led    = thermometer(mag_sum);
  assign exp_reads  = (exp_mode == MODE_VOICED) ? 4 : 0;

  tb_clock_gen clock_gen (.CLK_50M(CLK_50M), .rst_n(rst_n));

  flash_model flash (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .read(flash_read), .address(flash_address),
    .waitrequest(flash_waitrequest), .readdata(flash_readdata),
    .readdatavalid(flash_readdatavalid));

  narrator_top dut (.*);

  always @(posedge CLK_50M)
  begin
    cycle     <= cycle + 1;
    hold_addr <= flash_address;
    if (char_valid && char_ready)  // New phoneme clears the tally
    begin
      smp_cnt    <= 0;
      mag_sum    <= 0;
      exact_gaps <= 0;
      reads_acc  <= 0;
    end
    else
    begin
      if (sample_valid)
      begin
        smp_cnt    <= smp_cnt + 1;
        mag_sum    <= mag_sum + magnitude(exp_sample);
        last_valid <= cycle;
        if (smp_cnt > 0 && cycle - last_valid == int'(sample_div))
          exact_gaps <= exact_gaps + 1;
      end
      if (flash_read && !flash_waitrequest)
        reads_acc <= reads_acc + 1;
    end
  end

  task automatic report_value(string name, logic [31:0] exp, logic [31:0] got);
    $display("FAIL %s exp %h got %h", name, exp, got);
    errors++;
  endtask

  task automatic report_plain(string what);
    $display("Error: %s", what);
    errors++;
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got == exp)
    else
      report_value(name, exp, got);
  endtask

  // ============================================================
  // Concurrent checks
  // ============================================================
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read)
    else report_value("flash_read", 1, $sampled(flash_read));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_address == hold_addr)
    else report_value("flash_address", $sampled(hold_addr), $sampled(flash_address));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && !flash_waitrequest |-> flash_address == exp_base + reads_acc)
    else report_value("flash_address", $sampled(exp_base + reads_acc),
                      $sampled(flash_address));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |-> sample == exp_sample)
    else report_value("sample", $sampled(exp_sample), $sampled(sample));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |-> smp_cnt < 16)
    else report_plain("more than 16 samples in one phoneme");
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid && smp_cnt > 0 |-> (cycle - last_valid) % sample_div == 0)
    else report_plain($sformatf("sample gap of %0d cycles is not a multiple of %0d",
                                $sampled(cycle - last_valid), $sampled(sample_div)));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    exp_mode == MODE_SILENT |-> !flash_read)
    else report_value("flash_read", 0, 1);

  // Rejected characters
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    exp_mode == MODE_INVALID |-> !sample_valid)
    else report_value("sample_valid", 0, 1);
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    exp_mode == MODE_INVALID |-> !phoneme_done)
    else report_value("phoneme_done", 0, 1);
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    exp_mode == MODE_INVALID |-> char_ready)
    else report_value("char_ready", 1, 0);
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    char_error |-> exp_mode == MODE_INVALID)
    else report_value("char_error", 0, 1);

  // End of phoneme
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    phoneme_done |-> smp_cnt == 16)
    else report_value("sample_valid count", 16, $sampled(smp_cnt));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    phoneme_done |-> led_level == exp_led)
    else report_value("led_level", $sampled(exp_led), $sampled(led_level));
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    phoneme_done |-> reads_acc == exp_reads)
    else report_value("flash read count", $sampled(exp_reads), $sampled(reads_acc));

  // ============================================================
  // Stimulus tasks
  // ============================================================
  task automatic step();
    @(posedge CLK_50M);
    #2;
  endtask

  task automatic report_timeout(string what);
    $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic send_char(byte ch, logic [1:0] mode, int base);
    int n;
    exp_mode   = mode;
    exp_base   = base;
    char_data  = ch;
    char_valid = 1'b1;
    n = 0;
    while (!char_ready && n < WAIT_LIMIT)
    begin
      step();
      n++;
    end
    if (n == WAIT_LIMIT)
      report_timeout("char_ready");
    step();  // Transfer on this edge
    char_valid = 1'b0;
  endtask

  task automatic wait_phoneme();
    int n;
    n = 0;
    while (!phoneme_done && n < WAIT_LIMIT)
    begin
      step();
      n++;
    end
    if (n == WAIT_LIMIT)
      report_timeout("phoneme_done");
    step();  // End of phoneme checks sample on this edge
  endtask

  // 0 is up, 1 is down, 2 is reset
  task automatic pulse_speed(int which);
    speed_up    = (which == 0);
    speed_down  = (which == 1);
    speed_reset = (which == 2);
    step();
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    if (which == 2)
      exp_div = DIV_DEFAULT;
    else if (which == 0)
      exp_div = (exp_div - DIV_STEP < DIV_MIN) ? DIV_MIN : exp_div - DIV_STEP;
    else
      exp_div = (exp_div + DIV_STEP > DIV_MAX) ? DIV_MAX : exp_div + DIV_STEP;
    check_value("sample_div", sample_div, exp_div);
    step();
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors == errors_at_start)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial
  begin
    int n;
    char_valid  = 1'b0;
    char_data   = '0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    n = 0;
    while (rst_n !== 1'b1 && n < WAIT_LIMIT)
    begin
      step();
      n++;
    end
    if (n == WAIT_LIMIT)
      report_timeout("reset release");
    step();

    check_value("char_ready", char_ready, 1);
    check_value("sample_div", sample_div, DIV_DEFAULT);
    check_value("flash_read", flash_read, 0);
    check_value("sample_valid", sample_valid, 0);
    check_value("char_error", char_error, 0);
    check_value("phoneme_done", phoneme_done, 0);
    check_value("led_level", led_level, 0);
    end_test("reset values");

    send_char("c", MODE_VOICED, 8);
    wait_phoneme();
    send_char("C", MODE_VOICED, 8);  // Same phoneme as lower case
    wait_phoneme();
    end_test("letters c and C");

    send_char(" ", MODE_SILENT, 0);
    wait_phoneme();
    end_test("space");

    send_char("7", MODE_INVALID, 0);
    check_value("char_error", char_error, 1);
    check_value("char_ready", char_ready, 1);
    repeat (2 * DIV_DEFAULT) step();  // Window for stray samples
    end_test("invalid character");

    pulse_speed(0);
    pulse_speed(0);
    check_value("sample_div", sample_div, 3272);
    pulse_speed(1);
    check_value("sample_div", sample_div, 3372);
    pulse_speed(2);
    repeat (40) pulse_speed(0);
    check_value("sample_div", sample_div, DIV_MIN);
    send_char("a", MODE_VOICED, 0);
    wait_phoneme();
    assert (exact_gaps >= 14)
    else
      report_plain($sformatf("only %0d of 15 sample gaps equal sample_div", exact_gaps));
    pulse_speed(2);
    end_test("sample rate control");

    send_char("z", MODE_VOICED, 100);  // Wraps into negative samples
    wait_phoneme();
    check_value("led_level", led_level, 8'h3f);
    end_test("level meter");

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* narrator.f */
+incdir+src
src/narrator_flash_pkg.sv
src/narrator_audio_pkg.sv
src/sample_rate_gen.sv
src/phoneme_sequencer.sv
src/flash_sample_reader.sv
src/level_meter.sv
src/narrator_top.sv
testbench/tb_clock_gen.sv
testbench/flash_model.sv
testbench/tb_narrator_top.sv

/* Bender.yml */
package:
  name: narrator

sources:
  - include_dirs:
      - src
    files:
      - src/narrator_flash_pkg.sv
      - src/narrator_audio_pkg.sv
      - src/sample_rate_gen.sv
      - src/phoneme_sequencer.sv
      - src/flash_sample_reader.sv
      - src/level_meter.sv
      - src/narrator_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/flash_model.sv
      - testbench/tb_narrator_top.sv
